// ==== compile.f ====
+incdir+common
common/div_pkg.sv
source/div_input_stage.sv
divider/div_control.sv
divider/div_datapath.sv
source/div_result_stage.sv
source/div_top.sv
verif/div_assert.sv
verif/tb_div_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_div_top
SEED      ?= 12997
BUILD_DIR ?= build
VFLAGS    ?= --binary --assert --timing -j 0
RUN_FLAGS ?= +verilator+error+limit+10

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f compile.f

run: compile
	$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_div_top.sv ====
`timescale 1ns/10ps

`include "div_cfg.svh"

module tb_div_top #(
    parameter int SEED = 12997
);

    import div_pkg::*;

    localparam int W          = `DIV_WIDTH;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    localparam int N_RANDOM   = 300;
    localparam int N_REQ      = N_RANDOM + 11;
    localparam int REQ_CYCLES = 3 * W + 8;
    localparam int MIN_VAL    = -(1 << (W - 1));
    localparam int MAX_VAL    = (1 << (W - 1)) - 1;

    logic     clk;
    logic     rst_n;
    logic     start;
    div_req_t req;
    logic     busy;
    div_res_t res;
    logic     valid;
    logic     dvz_err;
    logic     ovf_err;

    div_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .req     (req),
        .busy    (busy),
        .res     (res),
        .valid   (valid),
        .dvz_err (dvz_err),
        .ovf_err (ovf_err)
    );

    bind div_top div_assert i_div_assert (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .req     (req),
        .go      (go),
        .busy    (busy),
        .res     (res),
        .valid   (valid),
        .dvz_err (dvz_err),
        .ovf_err (ovf_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic send(input int dividend, input int divisor);
        @(posedge clk);
        start        <= 1'b1;
        req.dividend <= W'(dividend);
        req.divisor  <= W'(divisor);
        @(posedge clk);
        start <= 1'b0;
    endtask

    // outputs are read just after the edge, before the DUT updates them.
    task automatic wait_end();
        do begin
            @(posedge clk);
        end while (!(valid || dvz_err || ovf_err));
    endtask

    task automatic divide(input int dividend, input int divisor);
        send(dividend, divisor);
        wait_end();
    endtask

    initial begin
        int dvd;
        int dvs;
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        divide(7, 2);
        divide(-7, 2);
        divide(7, -2);
        divide(-7, -2);
        divide(MIN_VAL, 1);
        divide(MIN_VAL, MIN_VAL);
        divide(MAX_VAL, -1);
        divide(3, 11);
        divide(1234, 0);        // aborts, the last result stays.
        divide(MIN_VAL, -1);

        // a second start in the middle of a division has to be dropped.
        send(-1000, 7);
        repeat (4) @(posedge clk);
        start <= 1'b1;
        req   <= '0;
        @(posedge clk);
        start <= 1'b0;
        wait_end();

        for (int i = 0; i < N_RANDOM; i++) begin
            dvd = int'($urandom);
            dvs = ($urandom % 2 == 0) ? int'($urandom % 300) - 150 : int'($urandom);
            divide(dvd, dvs);
        end

        repeat (10) @(posedge clk);
        if (i_dut.i_div_assert.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failures were counted during the run");
        end
    end

    initial begin
        wait (i_dut.i_div_assert.fail_cnt != 0);
        $display("TESTBENCH FAILED");
        $fatal(1, "an assertion on the divider failed");
    end

    // each request takes at most three cycles per bit plus a few for load and result.
    initial begin
        repeat (RST_CYCLES + N_REQ * REQ_CYCLES + 200) @(posedge clk);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout, the divider did not finish its requests in time");
    end

endmodule

// ==== verif/div_assert.sv ====
`timescale 1ns/10ps

`include "div_cfg.svh"

module div_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              start,
    input div_pkg::div_req_t req,
    input logic              go,
    input logic              busy,
    input div_pkg::div_res_t res,
    input logic              valid,
    input logic              dvz_err,
    input logic              ovf_err
);

    import div_pkg::*;

    localparam logic signed [`DIV_WIDTH-1:0] MOST_NEG = {1'b1, {(`DIV_WIDTH-1){1'b0}}};

    logic                         accept;
    logic                         end_mark;
    logic                         ovf_req;
    logic                         pending;
    logic                         exp_dvz;
    logic                         exp_ovf;
    logic signed [`DIV_WIDTH-1:0] exp_q;
    logic signed [`DIV_WIDTH-1:0] exp_r;
    int                           fail_cnt = 0;

    assign accept   = start && !busy && !go;
    assign end_mark = valid || dvz_err || ovf_err;
    assign ovf_req  = (req.dividend == MOST_NEG) && (req.divisor == '1);

    // expected outcome of the request in flight, truncating signed division.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            exp_dvz <= 1'b0;
            exp_ovf <= 1'b0;
            exp_q   <= '0;
            exp_r   <= '0;
        end else if (accept) begin
            pending <= 1'b1;
            exp_dvz <= (req.divisor == '0);
            exp_ovf <= ovf_req;
            if (req.divisor != '0 && !ovf_req) begin
                exp_q <= req.dividend / req.divisor;
                exp_r <= req.dividend % req.divisor;   // takes the sign of the dividend.
            end
        end else if (end_mark) begin
            pending <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // results and end markers
    // ----------------------------------------------------------------------
    a_quotient: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> res.quotient == exp_q)
        else begin
            fail_cnt++;
            $error("mismatch res.quotient: got %h, expected %h",
                   $sampled(res.quotient), $sampled(exp_q));
        end

    a_remainder: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> res.remainder == exp_r)
        else begin
            fail_cnt++;
            $error("mismatch res.remainder: got %h, expected %h",
                   $sampled(res.remainder), $sampled(exp_r));
        end

    // exactly one marker, and the one that fits the operands.
    a_marker: assert property (@(posedge clk) disable iff (!rst_n)
        end_mark |-> pending && (valid == !(exp_dvz || exp_ovf))
                     && (dvz_err == exp_dvz) && (ovf_err == exp_ovf))
        else begin
            fail_cnt++;
            $error("end marker does not fit the accepted request");
        end

    a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !pending || end_mark)
        else begin
            fail_cnt++;
            $error("a request was taken while another one was still in flight");
        end

    a_res_held: assert property (@(posedge clk) disable iff (!rst_n) !valid |-> $stable(res))
        else begin
            fail_cnt++;
            $error("result changed without a valid pulse");
        end

    // ----------------------------------------------------------------------
    // busy and reset
    // ----------------------------------------------------------------------
    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n) go |=> busy)
        else begin
            fail_cnt++;
            $error("busy did not rise one cycle after the request was taken");
        end

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n) end_mark == $fell(busy))
        else begin
            fail_cnt++;
            $error("busy did not fall together with the end marker");
        end

    a_reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n))
        |-> !busy && !valid && !dvz_err && !ovf_err && res == '0)
        else begin
            fail_cnt++;
            $error("outputs are not quiet during or right after reset");
        end

endmodule

// ==== source/div_top.sv ====
`timescale 1ns/10ps

module div_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  div_pkg::div_req_t req,
    output logic              busy,
    output div_pkg::div_res_t res,
    output logic              valid,
    output logic              dvz_err,
    output logic              ovf_err
);

    import div_pkg::*;

    div_oper_t oper;
    div_rq_u   rq;
    logic      go;
    logic      ld_ops;
    logic      clr;
    logic      sub_en;
    logic      shift_en;
    logic      done;
    logic      abort_dvz;
    logic      abort_ovf;
    logic      dvz;
    logic      gte;
    logic      co_cnt;

    // ----------------------------------------------------------------------
    // request capture, control, datapath and result
    // ----------------------------------------------------------------------
    div_input_stage i_input (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .req   (req),
        .busy  (busy),
        .go    (go),
        .oper  (oper)
    );

    div_control i_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .dvz       (dvz),
        .gte       (gte),
        .co_cnt    (co_cnt),
        .ovf       (oper.ovf),
        .busy      (busy),
        .ld_ops    (ld_ops),
        .clr       (clr),
        .sub_en    (sub_en),
        .shift_en  (shift_en),
        .done      (done),
        .abort_dvz (abort_dvz),
        .abort_ovf (abort_ovf)
    );

    div_datapath i_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .ld_ops   (ld_ops),
        .clr      (clr),
        .sub_en   (sub_en),
        .shift_en (shift_en),
        .oper     (oper),
        .rq       (rq),
        .dvz      (dvz),
        .gte      (gte),
        .co_cnt   (co_cnt)
    );

    div_result_stage i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .abort_dvz (abort_dvz),
        .abort_ovf (abort_ovf),
        .rq        (rq),
        .neg_q     (oper.neg_q),
        .neg_r     (oper.neg_r),
        .res       (res),
        .valid     (valid),
        .dvz_err   (dvz_err),
        .ovf_err   (ovf_err)
    );

endmodule

// ==== source/div_result_stage.sv ====
`timescale 1ns/10ps

`include "div_cfg.svh"

module div_result_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             done,
    input  logic             abort_dvz,
    input  logic             abort_ovf,
    input  div_pkg::div_rq_u rq,
    input  logic             neg_q,
    input  logic             neg_r,
    output div_pkg::div_res_t res,
    output logic             valid,
    output logic             dvz_err,
    output logic             ovf_err
);

    logic [`DIV_WIDTH-1:0] quo_mag;
    logic [`DIV_WIDTH-1:0] rem_mag;

    // the final shift leaves the whole word one bit up, undo it here.
    assign quo_mag = {rq.fields.rem[0], rq.fields.quo[`DIV_WIDTH-1:1]};
    assign rem_mag = {1'b0, rq.fields.rem[`DIV_WIDTH-1:1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res     <= '0;
            valid   <= 1'b0;
            dvz_err <= 1'b0;
            ovf_err <= 1'b0;
        end else begin
            valid   <= done;
            dvz_err <= abort_dvz;
            ovf_err <= abort_ovf;
            if (done) begin
                res.quotient  <= neg_q ? -quo_mag : quo_mag;
                res.remainder <= neg_r ? -rem_mag : rem_mag;   // sign of the dividend.
            end
        end
    end

endmodule

// ==== divider/div_datapath.sv ====
`timescale 1ns/10ps

`include "div_cfg.svh"

module div_datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ld_ops,
    input  logic               clr,
    input  logic               sub_en,
    input  logic               shift_en,
    input  div_pkg::div_oper_t oper,
    output div_pkg::div_rq_u   rq,
    output logic               dvz,
    output logic               gte,
    output logic               co_cnt
);

    localparam int unsigned           CNT_W    = `DIV_CNT_WIDTH;
    localparam logic [CNT_W-1:0]      CNT_LAST = CNT_W'(`DIV_WIDTH - 1);

    logic [`DIV_WIDTH-1:0] divisor_q;
    logic [CNT_W-1:0]      bit_cnt;

    // ----------------------------------------------------------------------
    // operand and partial remainder registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ld_ops) begin
            divisor_q <= oper.divisor_mag;
            // the dividend goes in one bit up, so its top bit already sits in rem
            // for the first compare.
            rq.bits <= {{`DIV_WIDTH{1'b0}}, oper.dividend_mag} << 1;
        end else if (sub_en) begin
            rq.fields.rem    <= rq.fields.rem - divisor_q;
            rq.fields.quo[0] <= 1'b1;   // quotient bit of this step.
        end else if (shift_en) begin
            rq.bits <= rq.bits << 1;    // brings down the next dividend bit.
        end
    end

    // ----------------------------------------------------------------------
    // bit counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (clr) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // rem stays below the divisor magnitude, at most half the range, so the
    // shifted value never loses its top bit.
    assign dvz    = (divisor_q == '0);
    assign gte    = (rq.fields.rem >= divisor_q);
    assign co_cnt = shift_en && (bit_cnt == CNT_LAST);   // last of the shifts.

endmodule

// ==== divider/div_control.sv ====
`timescale 1ns/10ps

module div_control (
    input  logic clk,
    input  logic rst_n,
    input  logic go,
    input  logic dvz,
    input  logic gte,
    input  logic co_cnt,
    input  logic ovf,
    output logic busy,
    output logic ld_ops,
    output logic clr,
    output logic sub_en,
    output logic shift_en,
    output logic done,
    output logic abort_dvz,
    output logic abort_ovf
);

    import div_pkg::*;

    div_state_e state;
    div_state_e next_state;
    logic       next_abort_dvz;
    logic       next_abort_ovf;

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin
        next_state     = state;
        next_abort_dvz = 1'b0;
        next_abort_ovf = 1'b0;
        case (state)
            S_IDLE: begin
                if (go) begin
                    next_state = S_LOAD;
                end
            end
            S_LOAD: next_state = S_CHECK;
            S_CHECK: begin
                if (dvz) begin
                    next_state     = S_IDLE;
                    next_abort_dvz = 1'b1;
                end else begin
                    next_state = S_DIVIDE;
                end
            end
            S_DIVIDE: next_state = gte ? S_SUB : S_SHIFT;
            S_SUB: next_state = S_SHIFT;
            S_SHIFT: begin
                // overflow is known from the start, one pass through the loop is enough.
                if (ovf) begin
                    next_state     = S_IDLE;
                    next_abort_ovf = 1'b1;
                end else if (co_cnt) begin
                    next_state = S_DONE;
                end else begin
                    next_state = S_DIVIDE;
                end
            end
            S_DONE: next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // state and strobes, each strobe is high for the whole of its state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            busy      <= 1'b0;
            ld_ops    <= 1'b0;
            clr       <= 1'b0;
            sub_en    <= 1'b0;
            shift_en  <= 1'b0;
            done      <= 1'b0;
            abort_dvz <= 1'b0;
            abort_ovf <= 1'b0;
        end else begin
            state     <= next_state;
            // busy covers the abort cycle, so it drops together with done and abort alike.
            busy      <= (next_state != S_IDLE) || next_abort_dvz || next_abort_ovf;
            ld_ops    <= (next_state == S_LOAD);
            clr       <= (next_state == S_LOAD);
            sub_en    <= (next_state == S_SUB);
            shift_en  <= (next_state == S_SHIFT);
            done      <= (next_state == S_DONE);
            abort_dvz <= next_abort_dvz;
            abort_ovf <= next_abort_ovf;
        end
    end

endmodule

// ==== source/div_input_stage.sv ====
`timescale 1ns/10ps

`include "div_cfg.svh"

module div_input_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  div_pkg::div_req_t req,
    input  logic              busy,
    output logic              go,
    output div_pkg::div_oper_t oper
);

    localparam logic [`DIV_WIDTH-1:0] MOST_NEG = {1'b1, {(`DIV_WIDTH-1){1'b0}}};

    logic accept;
    logic dvd_neg;
    logic dvs_neg;

    // go is still high in the cycle before busy rises, so it blocks too.
    assign accept  = start && !busy && !go;
    assign dvd_neg = req.dividend[`DIV_WIDTH-1];
    assign dvs_neg = req.divisor[`DIV_WIDTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go <= 1'b0;
        end else begin
            go <= accept;
        end
    end

    // the most negative value negates to itself, which is the right magnitude bit pattern.
    always_ff @(posedge clk) begin
        if (accept) begin
            oper.dividend_mag <= dvd_neg ? -req.dividend : req.dividend;
            oper.divisor_mag  <= dvs_neg ? -req.divisor : req.divisor;
            oper.neg_q        <= dvd_neg ^ dvs_neg;
            oper.neg_r        <= dvd_neg;   // remainder follows the dividend.
            oper.ovf          <= (req.dividend == MOST_NEG) && (req.divisor == '1);
        end
    end

endmodule

// ==== common/div_pkg.sv ====
`include "div_cfg.svh"

package div_pkg;

    // ----------------------------------------------------------------------
    // request and result words
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic signed [`DIV_WIDTH-1:0] dividend;
        logic signed [`DIV_WIDTH-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic signed [`DIV_WIDTH-1:0] quotient;
        logic signed [`DIV_WIDTH-1:0] remainder;
    } div_res_t;

    // operands as magnitudes, with the signs the result stage puts back.
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend_mag;
        logic [`DIV_WIDTH-1:0] divisor_mag;
        logic                  neg_q;
        logic                  neg_r;
        logic                  ovf;    // most negative dividend over minus one.
    } div_oper_t;

    // ----------------------------------------------------------------------
    // partial remainder and quotient, shifted as one word
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] rem;
        logic [`DIV_WIDTH-1:0] quo;
    } div_rq_fields_t;

    typedef union packed {
        logic [2*`DIV_WIDTH-1:0] bits;
        div_rq_fields_t          fields;
    } div_rq_u;

    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_LOAD   = 3'd1,
        S_CHECK  = 3'd2,
        S_DIVIDE = 3'd3,
        S_SUB    = 3'd4,
        S_SHIFT  = 3'd5,
        S_DONE   = 3'd6
    } div_state_e;

endpackage

// ==== common/div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result width in bits, any even value from 4 upward.
`define DIV_WIDTH 16

// the bit counter has to hold DIV_WIDTH itself, one more bit than the index.
`define DIV_CNT_WIDTH ($clog2(`DIV_WIDTH) + 1)

`endif
